// File: logic/cmd_pkg.sv
// shared constants and frame layout; opcode and register codes follow the host software
`default_nettype none

package cmd_pkg;

   localparam int FRAME_BYTES = 8;
   localparam int BYTE_W      = 8;
   localparam int WORD_W      = 32;
   localparam int THRESH_W    = 12;

   localparam logic [31:0] FIRMWARE_VERSION = 32'd26;

   // command opcodes, byte 0 of a frame
   localparam logic [7:0] OP_STATUS     = 8'd2;
   localparam logic [7:0] OP_SPI        = 8'd3;
   localparam logic [7:0] OP_SPI_MODE   = 8'd4;
   localparam logic [7:0] OP_TRIG_SET   = 8'd8;
   localparam logic [7:0] OP_DOWNSAMPLE = 8'd9;
   localparam logic [7:0] OP_READ_REG   = 8'd14;

   // status sub-codes, byte 1 of an OP_STATUS frame
   localparam logic [7:0] ST_VERSION   = 8'd0;
   localparam logic [7:0] ST_FAN       = 8'd6;
   localparam logic [7:0] ST_PRELENGTH = 8'd7;
   localparam logic [7:0] ST_ROLLING   = 8'd8;
   localparam logic [7:0] ST_AUXSEL    = 8'd10;

   // read-register codes, byte 1 of an OP_READ_REG frame
   localparam logic [7:0] RR_PREOFFSET  = 8'd0;
   localparam logic [7:0] RR_SPISTATE   = 8'd2;
   localparam logic [7:0] RR_VERSION    = 8'd3;
   localparam logic [7:0] RR_MERGING    = 8'd9;
   localparam logic [7:0] RR_DOWNSAMPLE = 8'd10;
   localparam logic [7:0] RR_HIGHRES    = 8'd11;
   localparam logic [7:0] RR_UPPER      = 8'd12;

   // byte 0 is the first byte received and sits in the low bits
   typedef union packed {
      logic [FRAME_BYTES-1:0][BYTE_W-1:0] bytes;
      struct packed {
         logic [7:0] arg6, arg5, arg4, arg3, arg2, arg1;
         logic [7:0] sel;
         logic [7:0] opcode;
      } f;
   } cmd_frame_u;

endpackage

`default_nettype wire

// File: logic/frame_receiver.sv
// no framing recovery: every 8 accepted bytes form one frame, a lost byte shifts all later frames
`timescale 1ns/10ps
`default_nettype none

module frame_receiver (
   input  wire                         clk50,
   input  wire                         pllreset2,
   input  wire                         i_rx_tvalid,
   output logic                        o_rx_tready,
   input  wire  [cmd_pkg::BYTE_W-1:0]  i_rx_tdata,
   output cmd_pkg::cmd_frame_u         o_frame,
   output logic                        o_frame_valid,
   input  wire                         i_frame_ready
);
   import cmd_pkg::*;

   logic [$clog2(FRAME_BYTES)-1:0] byte_cnt;
   logic                           rx_fire;

   assign o_rx_tready = !o_frame_valid; // stall while a full frame waits
   assign rx_fire     = i_rx_tvalid && o_rx_tready;

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         byte_cnt      <= '0;
         o_frame_valid <= 1'b0;
      end else if (o_frame_valid) begin
         if (i_frame_ready) o_frame_valid <= 1'b0; // handed over
      end else if (rx_fire) begin
         byte_cnt <= byte_cnt + 1'b1; // wraps after the last byte
         if (byte_cnt == ($clog2(FRAME_BYTES))'(FRAME_BYTES - 1)) o_frame_valid <= 1'b1;
      end
   end

   always_ff @(posedge clk50) begin
      if (rx_fire) o_frame.bytes[byte_cnt] <= i_rx_tdata;
   end

endmodule

`default_nettype wire

// File: logic/cmd_sequencer.sv
// one command at a time; the frame is acked only when its work is done so it stays stable meanwhile
`timescale 1ns/10ps
`default_nettype none

module cmd_sequencer #(
   parameter int unsigned CS_SETUP_CYCLES = 10,
   parameter int unsigned CS_HOLD_CYCLES  = 35
) (
   input  wire                         clk50,
   input  wire                         pllreset2,
   input  wire cmd_pkg::cmd_frame_u    i_frame,
   input  wire                         i_frame_valid,
   output logic                        o_frame_ack,
   output logic                        o_reg_apply,
   input  wire  [cmd_pkg::WORD_W-1:0]  i_reg_reply,
   output logic                        o_spi_start,
   input  wire                         i_spi_done,
   input  wire  [15:0]                 i_spi_reply,
   output logic [7:0]                  o_spi_cs,
   output logic [2:0]                  o_spi_miso_sel,
   output logic                        o_timer_load,
   output logic [7:0]                  o_timer_count,
   input  wire                         i_timer_expired,
   output logic                        o_tx_tvalid,
   input  wire                         i_tx_tready,
   output logic [cmd_pkg::WORD_W-1:0]  o_tx_tdata,
   output logic [3:0]                  o_busy_state
);
   import cmd_pkg::*;

   localparam logic [3:0] S_IDLE  = 4'd0;
   localparam logic [3:0] S_APPLY = 4'd1;
   localparam logic [3:0] S_SETUP = 4'd2;
   localparam logic [3:0] S_START = 4'd3;
   localparam logic [3:0] S_XFER  = 4'd4;
   localparam logic [3:0] S_HOLD  = 4'd5;
   localparam logic [3:0] S_TX    = 4'd6;

   logic [3:0] state;
   logic       is_reg_op;
   logic       is_spi_op;

   assign is_reg_op = i_frame.f.opcode inside {OP_STATUS, OP_SPI_MODE, OP_TRIG_SET,
                                               OP_DOWNSAMPLE, OP_READ_REG};
   assign is_spi_op = i_frame.f.opcode == OP_SPI;

   // unknown opcodes are acked straight from idle and dropped
   assign o_frame_ack = (state == S_APPLY) || (state == S_HOLD && i_timer_expired) ||
                        (state == S_IDLE && i_frame_valid && !is_reg_op && !is_spi_op);

   assign o_reg_apply   = state == S_APPLY;
   assign o_spi_start   = state == S_START;
   assign o_timer_load  = (state == S_IDLE && i_frame_valid && is_spi_op) ||
                          (state == S_XFER && i_spi_done);
   assign o_timer_count = (state == S_IDLE) ? 8'(CS_SETUP_CYCLES) : 8'(CS_HOLD_CYCLES);
   assign o_tx_tvalid   = state == S_TX;
   assign o_busy_state  = state;

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         state          <= S_IDLE;
         o_spi_cs       <= '1;
         o_spi_miso_sel <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (i_frame_valid && is_reg_op) state <= S_APPLY;
               else if (i_frame_valid && is_spi_op) begin
                  o_spi_cs       <= ~(8'd1 << i_frame.f.sel[2:0]); // select one chip
                  o_spi_miso_sel <= i_frame.f.sel[2:0];
                  state          <= S_SETUP;
               end
            end
            S_APPLY: state <= S_TX;
            S_SETUP: if (i_timer_expired) state <= S_START; // cs setup time
            S_START: state <= S_XFER;
            S_XFER:  if (i_spi_done) state <= S_HOLD;
            S_HOLD: begin
               if (i_timer_expired) begin
                  o_spi_cs <= '1; // release after hold time
                  state    <= S_TX;
               end
            end
            S_TX:    if (i_tx_tready) state <= S_IDLE;
            default: state <= S_IDLE;
         endcase
      end
   end

   // response beat
   always_ff @(posedge clk50) begin
      if (state == S_APPLY) o_tx_tdata <= i_reg_reply;
      else if (state == S_XFER && i_spi_done) o_tx_tdata <= WORD_W'(i_spi_reply);
   end

endmodule

`default_nettype wire

// File: logic/wait_timer.sv
// a load with count 0 never expires; the flag stays high until the next load
`timescale 1ns/10ps
`default_nettype none

module wait_timer #(
   parameter int WIDTH = 8
) (
   input  wire              clk50,
   input  wire              pllreset2,
   input  wire              i_load,
   input  wire  [WIDTH-1:0] i_count,
   output logic             o_expired
);

   logic [WIDTH-1:0] remaining;

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         remaining <= '0;
         o_expired <= 1'b0;
      end else if (i_load) begin
         remaining <= i_count;
         o_expired <= 1'b0;
      end else if (remaining != '0) begin
         remaining <= remaining - 1'b1;
         if (remaining == WIDTH'(1)) o_expired <= 1'b1; // sticky
      end
   end

endmodule

`default_nettype wire

// File: logic/spi_transfer.sv
// byte count comes from frame byte 7, outside 2..4 it falls back to 2; no timeout on the SPI master
`timescale 1ns/10ps
`default_nettype none

module spi_transfer (
   input  wire                         clk50,
   input  wire                         pllreset2,
   input  wire                         i_start,
   input  wire cmd_pkg::cmd_frame_u    i_frame,
   output logic [cmd_pkg::BYTE_W-1:0]  o_spi_tx,
   output logic                        o_spi_tx_dv,
   input  wire                         i_spi_tx_ready,
   input  wire  [cmd_pkg::BYTE_W-1:0]  i_spi_rx,
   input  wire                         i_spi_rx_dv,
   output logic                        o_done,
   output logic [15:0]                 o_reply
);
   import cmd_pkg::*;

   localparam logic [1:0] X_IDLE = 2'd0;
   localparam logic [1:0] X_SEND = 2'd1;
   localparam logic [1:0] X_RECV = 2'd2;

   logic [1:0]        state;
   logic [1:0]        byte_idx;
   logic [2:0]        n_bytes;
   logic              last_byte;
   logic [BYTE_W-1:0] rx_byte;

   assign n_bytes   = (i_frame.bytes[7] inside {8'd2, 8'd3, 8'd4}) ? i_frame.bytes[7][2:0] : 3'd2;
   assign last_byte = {1'b0, byte_idx} == n_bytes - 3'd1;
   assign rx_byte   = i_spi_rx;

   assign o_spi_tx    = i_frame.bytes[3'd2 + {1'b0, byte_idx}]; // payload starts at byte 2
   assign o_spi_tx_dv = (state == X_SEND) && i_spi_tx_ready;

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         state    <= X_IDLE;
         byte_idx <= '0;
         o_done   <= 1'b0;
      end else begin
         o_done <= 1'b0;
         case (state)
            X_IDLE: begin
               byte_idx <= '0;
               if (i_start) state <= X_SEND;
            end
            X_SEND: if (i_spi_tx_ready) state <= X_RECV; // strobe goes out this cycle
            X_RECV: begin
               if (i_spi_rx_dv) begin
                  if (last_byte) begin
                     o_done <= 1'b1;
                     state  <= X_IDLE;
                  end else begin
                     byte_idx <= byte_idx + 1'b1;
                     state    <= X_SEND;
                  end
               end
            end
            default: state <= X_IDLE;
         endcase
      end
   end

   // last two answers, older one on top
   always_ff @(posedge clk50) begin
      if (state == X_RECV && i_spi_rx_dv) o_reply <= {o_reply[7:0], rx_byte};
   end

endmodule

`default_nettype wire

// File: logic/settings_regs.sv
// reply is combinational and shows the values from before the write that i_apply triggers
`timescale 1ns/10ps
`default_nettype none

module settings_regs (
   input  wire                                 clk50,
   input  wire                                 pllreset2,
   input  wire cmd_pkg::cmd_frame_u            i_frame,
   input  wire                                 i_apply,
   input  wire  [3:0]                          i_busy_state,
   output logic [cmd_pkg::WORD_W-1:0]          o_reply,
   output logic signed [cmd_pkg::THRESH_W-1:0] o_lower_thresh,
   output logic signed [cmd_pkg::THRESH_W-1:0] o_upper_thresh,
   output logic [9:0]                          o_ram_preoffset,
   output logic [7:0]                          o_trigger_tot,
   output logic                                o_trigger_chan,
   output logic [4:0]                          o_downsample,
   output logic                                o_highres,
   output logic [7:0]                          o_downsample_merging,
   output logic                                o_fan_on,
   output logic [15:0]                         o_prelength,
   output logic                                o_do_rolling,
   output logic [3:0]                          o_aux_sel,
   output logic [1:0]                          o_spi_mode
);
   import cmd_pkg::*;

   logic [THRESH_W-1:0] lower_next;
   logic [THRESH_W-1:0] upper_next;

   // adc codes centred on 128, scaled to 12 bits
   assign lower_next = ((THRESH_W'(i_frame.f.sel) - THRESH_W'(i_frame.f.arg1) - THRESH_W'(128))
                        << 4) + THRESH_W'(8);
   assign upper_next = ((THRESH_W'(i_frame.f.sel) + THRESH_W'(i_frame.f.arg1) - THRESH_W'(128))
                        << 4) + THRESH_W'(8);

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         o_lower_thresh       <= '0;
         o_upper_thresh       <= '0;
         o_ram_preoffset      <= '0;
         o_trigger_tot        <= '0;
         o_trigger_chan       <= 1'b0;
         o_downsample         <= '0;
         o_highres            <= 1'b0;
         o_downsample_merging <= '0;
         o_fan_on             <= 1'b0;
         o_prelength          <= '0;
         o_do_rolling         <= 1'b0;
         o_aux_sel            <= '0;
         o_spi_mode           <= '0;
      end else if (i_apply) begin
         case (i_frame.f.opcode)
            OP_TRIG_SET: begin
               o_lower_thresh  <= signed'(lower_next);
               o_upper_thresh  <= signed'(upper_next);
               o_ram_preoffset <= {i_frame.f.arg2[1:0], i_frame.f.arg3};
               o_trigger_tot   <= i_frame.f.arg4;
               o_trigger_chan  <= i_frame.f.arg5[0];
            end
            OP_DOWNSAMPLE: begin
               o_downsample         <= i_frame.f.sel[4:0];
               o_highres            <= i_frame.f.arg1[0];
               o_downsample_merging <= i_frame.f.arg2;
            end
            OP_SPI_MODE: o_spi_mode <= i_frame.f.sel[1:0];
            OP_STATUS: begin
               case (i_frame.f.sel)
                  ST_FAN:       o_fan_on     <= i_frame.f.arg1[0];
                  ST_PRELENGTH: o_prelength  <= {i_frame.f.arg2, i_frame.f.arg1};
                  ST_ROLLING:   o_do_rolling <= i_frame.f.arg1[0];
                  ST_AUXSEL:    o_aux_sel    <= i_frame.f.arg1[3:0];
                  default:      ; // read-only codes
               endcase
            end
            default: ;
         endcase
      end
   end

   always_comb begin
      o_reply = '0;
      case (i_frame.f.opcode)
         OP_TRIG_SET:   o_reply = WORD_W'(OP_TRIG_SET);
         OP_DOWNSAMPLE: o_reply = WORD_W'(OP_DOWNSAMPLE);
         OP_SPI_MODE:   o_reply = WORD_W'(i_frame.f.sel);
         OP_STATUS: begin
            case (i_frame.f.sel)
               ST_VERSION:   o_reply = FIRMWARE_VERSION;
               ST_FAN:       o_reply = WORD_W'(o_fan_on);
               ST_PRELENGTH: o_reply = WORD_W'(o_prelength);
               ST_ROLLING:   o_reply = WORD_W'(o_do_rolling);
               ST_AUXSEL:    o_reply = WORD_W'(o_aux_sel);
               default:      o_reply = '0;
            endcase
         end
         OP_READ_REG: begin
            case (i_frame.f.sel)
               RR_PREOFFSET:  o_reply = WORD_W'(o_ram_preoffset);
               RR_SPISTATE:   o_reply = WORD_W'(i_busy_state);
               RR_VERSION:    o_reply = FIRMWARE_VERSION;
               RR_MERGING:    o_reply = WORD_W'(o_downsample_merging);
               RR_DOWNSAMPLE: o_reply = WORD_W'(o_downsample);
               RR_HIGHRES:    o_reply = WORD_W'(o_highres);
               RR_UPPER:      o_reply = WORD_W'(unsigned'(o_upper_thresh)); // no sign extension
               default:       o_reply = '0;
            endcase
         end
         default: o_reply = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: logic/usb_command_core.sv
// all ports in the clk50 domain; the USB bridge and SPI master must be synchronous to it
`timescale 1ns/10ps
`default_nettype none

module usb_command_core #(
   parameter int unsigned CS_SETUP_CYCLES = 10,
   parameter int unsigned CS_HOLD_CYCLES  = 35
) (
   input  wire                                 clk50,
   input  wire                                 pllreset2,
   input  wire                                 i_rx_tvalid,
   output logic                                o_rx_tready,
   input  wire  [cmd_pkg::BYTE_W-1:0]          i_rx_tdata,
   output logic                                o_tx_tvalid,
   input  wire                                 i_tx_tready,
   output logic [cmd_pkg::WORD_W-1:0]          o_tx_tdata,
   output logic [cmd_pkg::BYTE_W-1:0]          o_spi_tx,
   output logic                                o_spi_tx_dv,
   input  wire                                 i_spi_tx_ready,
   input  wire  [cmd_pkg::BYTE_W-1:0]          i_spi_rx,
   input  wire                                 i_spi_rx_dv,
   output logic [7:0]                          o_spi_cs,
   output logic [2:0]                          o_spi_miso_sel,
   output logic signed [cmd_pkg::THRESH_W-1:0] o_lower_thresh,
   output logic signed [cmd_pkg::THRESH_W-1:0] o_upper_thresh,
   output logic [9:0]                          o_ram_preoffset,
   output logic [7:0]                          o_trigger_tot,
   output logic                                o_trigger_chan,
   output logic [4:0]                          o_downsample,
   output logic                                o_highres,
   output logic [7:0]                          o_downsample_merging,
   output logic                                o_fan_on,
   output logic [15:0]                         o_prelength,
   output logic                                o_do_rolling,
   output logic [3:0]                          o_aux_sel,
   output logic [1:0]                          o_spi_mode
);
   import cmd_pkg::*;

   cmd_frame_u        frame;
   logic              frame_valid, frame_ack;
   logic              reg_apply;
   logic [WORD_W-1:0] reg_reply;
   logic              spi_start, spi_done;
   logic [15:0]       spi_reply;
   logic              timer_load, timer_expired;
   logic [7:0]        timer_count;
   logic [3:0]        busy_state;

   frame_receiver u_frame_receiver (
      .clk50, .pllreset2, .i_rx_tvalid, .o_rx_tready, .i_rx_tdata,
      .o_frame(frame), .o_frame_valid(frame_valid), .i_frame_ready(frame_ack)
   );

   cmd_sequencer #(
      .CS_SETUP_CYCLES(CS_SETUP_CYCLES),
      .CS_HOLD_CYCLES (CS_HOLD_CYCLES)
   ) u_cmd_sequencer (
      .clk50, .pllreset2, .i_frame(frame), .i_frame_valid(frame_valid),
      .o_frame_ack(frame_ack), .o_reg_apply(reg_apply), .i_reg_reply(reg_reply),
      .o_spi_start(spi_start), .i_spi_done(spi_done), .i_spi_reply(spi_reply),
      .o_spi_cs, .o_spi_miso_sel, .o_timer_load(timer_load), .o_timer_count(timer_count),
      .i_timer_expired(timer_expired), .o_tx_tvalid, .i_tx_tready, .o_tx_tdata,
      .o_busy_state(busy_state)
   );

   wait_timer #(.WIDTH(8)) u_cs_timer ( // shared by cs setup and hold
      .clk50, .pllreset2, .i_load(timer_load), .i_count(timer_count),
      .o_expired(timer_expired)
   );

   spi_transfer u_spi_transfer (
      .clk50, .pllreset2, .i_start(spi_start), .i_frame(frame), .o_spi_tx, .o_spi_tx_dv,
      .i_spi_tx_ready, .i_spi_rx, .i_spi_rx_dv, .o_done(spi_done), .o_reply(spi_reply)
   );

   settings_regs u_settings_regs (
      .clk50, .pllreset2, .i_frame(frame), .i_apply(reg_apply), .i_busy_state(busy_state),
      .o_reply(reg_reply), .o_lower_thresh, .o_upper_thresh, .o_ram_preoffset,
      .o_trigger_tot, .o_trigger_chan, .o_downsample, .o_highres, .o_downsample_merging,
      .o_fan_on, .o_prelength, .o_do_rolling, .o_aux_sel, .o_spi_mode
   );

endmodule

`default_nettype wire

// File: verif/tb_usb_command_core.sv
// directed tests only; SPI chip model answers each byte XOR 8'hA5 after 1 to 4 cycles
`timescale 1ns/10ps
`default_nettype none

module tb_usb_command_core;
   import cmd_pkg::*;

   localparam int WAIT_LIMIT = 300; // cycles per wait before giving up

   logic clk50, pllreset2;
   logic i_rx_tvalid, o_rx_tready, o_tx_tvalid, i_tx_tready;
   logic [7:0] i_rx_tdata, o_spi_tx, i_spi_rx, o_spi_cs;
   logic [31:0] o_tx_tdata;
   logic o_spi_tx_dv, i_spi_tx_ready, i_spi_rx_dv;
   logic [2:0] o_spi_miso_sel;
   logic signed [11:0] o_lower_thresh, o_upper_thresh;
   logic [9:0] o_ram_preoffset;
   logic [7:0] o_trigger_tot, o_downsample_merging;
   logic o_trigger_chan, o_highres, o_fan_on, o_do_rolling;
   logic [4:0] o_downsample;
   logic [15:0] o_prelength;
   logic [3:0] o_aux_sel;
   logic [1:0] o_spi_mode;

   string cur_test;
   int errors = 0;
   int checks = 0;
   int tests = 0;
   int test_start_errors;
   logic [7:0] exp_cs = 8'hFF;
   logic [7:0] model_bytes[$]; // bytes seen by the SPI chip model

   usb_command_core #(.CS_SETUP_CYCLES(10), .CS_HOLD_CYCLES(35)) DUT (.*);

   initial begin
      clk50 = 1'b0;
      forever #4 clk50 = ~clk50; // 125 MHz stand-in
   end

   task automatic close_run();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   endtask

   task automatic abort_on_timeout(input string what);
      $display("%s: timed out waiting for %s", cur_test, what);
      errors++;
      close_run();
   endtask

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         $display("FAILED %s: %s expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
         errors++;
      end
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      test_start_errors = errors;
   endtask

   task automatic report_test();
      tests++;
      $display("%s: %s", cur_test, (errors == test_start_errors) ? "passed" : "FAILED");
   endtask

   function automatic logic [63:0] build_frame(input logic [7:0] op, sel, a1, a2, a3, a4, a5, a6);
      return {a6, a5, a4, a3, a2, a1, sel, op}; // byte 0 lowest
   endfunction

   task automatic send_frame(input logic [63:0] fr);
      int cnt;
      bit accepted;
      for (int i = 0; i < 8; i++) begin
         i_rx_tvalid <= 1'b1;
         i_rx_tdata  <= fr[8*i +: 8];
         accepted = 1'b0;
         cnt = 0;
         while (!accepted && cnt < WAIT_LIMIT) begin
            @(posedge clk50);
            accepted = o_rx_tready; // valid was high on this edge
            cnt++;
         end
         if (!accepted) abort_on_timeout("the receiver to take a frame byte");
      end
      i_rx_tvalid <= 1'b0;
   endtask

   task automatic get_reply(input bit stall, output logic [31:0] data);
      int cnt;
      bit done;
      bit seen;
      logic [31:0] held;
      cnt = 0;
      done = 1'b0;
      seen = 1'b0;
      held = '0;
      data = '0;
      while (!done && cnt < WAIT_LIMIT) begin
         @(posedge clk50);
         cnt++;
         if (o_tx_tvalid) begin
            if (seen) check_value("held beat", held, o_tx_tdata);
            held = o_tx_tdata;
            seen = 1'b1;
            if (i_tx_tready) begin
               done = 1'b1;
               data = o_tx_tdata;
            end
         end
         if (stall) i_tx_tready <= ($urandom_range(0, 3) == 0); // mostly stalled
      end
      i_tx_tready <= 1'b1;
      if (!done) abort_on_timeout("a response beat");
   endtask

   task automatic watch_for_no_beat(input int cycles);
      bit got;
      got = 1'b0;
      for (int i = 0; i < cycles; i++) begin
         @(posedge clk50);
         if (o_tx_tvalid) got = 1'b1;
      end
      checks++;
      assert (!got) else begin
         $display("%s: a response beat came for a discarded opcode", cur_test);
         errors++;
      end
   endtask

   // chip model: one answer per strobe, tx_ready low while busy
   initial begin : spi_chip_model
      logic [7:0] b;
      int d;
      i_spi_tx_ready = 1'b1;
      i_spi_rx_dv    = 1'b0;
      i_spi_rx       = 8'h00;
      forever begin
         @(posedge clk50);
         i_spi_rx_dv <= 1'b0;
         if (!pllreset2 && o_spi_tx_dv) begin
            b = o_spi_tx;
            model_bytes.push_back(b);
            check_value("chip select during transfer", exp_cs, o_spi_cs);
            i_spi_tx_ready <= 1'b0;
            d = $urandom_range(1, 4);
            repeat (d) @(posedge clk50);
            i_spi_rx       <= b ^ 8'hA5;
            i_spi_rx_dv    <= 1'b1;
            i_spi_tx_ready <= 1'b1;
         end
      end
   end

   task automatic reset_state_check();
      logic [31:0] rep;
      start_test("reset and version");
      check_value("tx valid", 32'd0, o_tx_tvalid);
      check_value("spi strobe", 32'd0, o_spi_tx_dv);
      check_value("chip selects", 32'hFF, o_spi_cs);
      check_value("rx ready", 32'd1, o_rx_tready);
      send_frame(build_frame(OP_STATUS, 8'd0, 0, 0, 0, 0, 0, 0));
      get_reply(1'b0, rep);
      check_value("version", 32'd26, rep);
      report_test();
   endtask

   task automatic trigger_settings();
      logic [31:0] rep;
      logic [7:0] sel, a1, a2, a3, a4, a5;
      int lo, hi;
      start_test("trigger settings");
      sel = 8'($urandom);
      a1  = 8'($urandom);
      a2  = 8'($urandom);
      a3  = 8'($urandom);
      a4  = 8'($urandom);
      a5  = 8'($urandom);
      lo = (int'(sel) - int'(a1) - 128) * 16 + 8;
      hi = (int'(sel) + int'(a1) - 128) * 16 + 8;
      send_frame(build_frame(OP_TRIG_SET, sel, a1, a2, a3, a4, a5, 8'd0));
      get_reply(1'b0, rep);
      check_value("reply", 32'd8, rep);
      check_value("lower threshold", lo[11:0], {20'd0, o_lower_thresh});
      check_value("upper threshold", hi[11:0], {20'd0, o_upper_thresh});
      check_value("preoffset", {a2[1:0], a3}, o_ram_preoffset);
      check_value("time over threshold", a4, o_trigger_tot);
      check_value("trigger channel", a5[0], o_trigger_chan);
      report_test();
   endtask

   task automatic downsample_readback();
      logic [31:0] rep;
      logic [7:0] sel, a1, a2;
      start_test("downsample readback");
      sel = 8'($urandom);
      a1  = 8'($urandom);
      a2  = 8'($urandom);
      send_frame(build_frame(OP_DOWNSAMPLE, sel, a1, a2, 0, 0, 0, 0));
      get_reply(1'b0, rep);
      check_value("reply", 32'd9, rep);
      check_value("downsample output", sel[4:0], o_downsample);
      check_value("highres output", a1[0], o_highres);
      check_value("merging output", a2, o_downsample_merging);
      send_frame(build_frame(OP_READ_REG, 8'd9, 0, 0, 0, 0, 0, 0));
      get_reply(1'b0, rep);
      check_value("merging", a2, rep);
      send_frame(build_frame(OP_READ_REG, 8'd10, 0, 0, 0, 0, 0, 0));
      get_reply(1'b0, rep);
      check_value("downsample", sel[4:0], rep);
      send_frame(build_frame(OP_READ_REG, 8'd11, 0, 0, 0, 0, 0, 0));
      get_reply(1'b0, rep);
      check_value("highres", a1[0], rep);
      send_frame(build_frame(OP_READ_REG, 8'd5, 0, 0, 0, 0, 0, 0)); // unused code
      get_reply(1'b0, rep);
      check_value("unknown register", 32'd0, rep);
      report_test();
   endtask

   task automatic status_fields();
      logic [31:0] rep;
      logic [7:0] a1, a2, md;
      start_test("status fields");
      a1 = 8'($urandom);
      a2 = 8'($urandom);
      md = 8'($urandom);
      send_frame(build_frame(OP_STATUS, 8'd7, a1, a2, 0, 0, 0, 0));
      get_reply(1'b0, rep);
      check_value("prelength old value", 32'd0, rep);
      check_value("prelength", {a2, a1}, o_prelength);
      send_frame(build_frame(OP_STATUS, 8'd8, 8'd1, 0, 0, 0, 0, 0));
      get_reply(1'b0, rep);
      check_value("rolling old value", 32'd0, rep);
      check_value("rolling", 32'd1, o_do_rolling);
      send_frame(build_frame(OP_STATUS, 8'd10, a1, 0, 0, 0, 0, 0));
      get_reply(1'b0, rep);
      check_value("aux select old value", 32'd0, rep);
      check_value("aux select", a1[3:0], o_aux_sel);
      send_frame(build_frame(OP_STATUS, 8'd10, 8'd0, 0, 0, 0, 0, 0));
      get_reply(1'b0, rep);
      check_value("aux select read back", a1[3:0], rep);
      send_frame(build_frame(OP_SPI_MODE, md, 0, 0, 0, 0, 0, 0));
      get_reply(1'b0, rep);
      check_value("spi mode reply", md, rep);
      check_value("spi mode", md[1:0], o_spi_mode);
      report_test();
   endtask

   task automatic spi_transactions();
      logic [31:0] rep;
      logic [7:0] pay[4];
      logic [2:0] chip;
      start_test("spi transactions");
      for (int n = 2; n <= 4; n++) begin
         chip = 3'($urandom_range(0, 7));
         for (int k = 0; k < 4; k++)
            pay[k] = 8'($urandom);
         exp_cs = 8'hFF;
         exp_cs[chip] = 1'b0; // only the addressed chip low
         model_bytes.delete();
         send_frame(build_frame(OP_SPI, {5'd0, chip}, pay[0], pay[1], pay[2], pay[3], 0, 8'(n)));
         get_reply(1'b0, rep);
         check_value("bytes sent", n, model_bytes.size());
         for (int k = 0; k < n && k < model_bytes.size(); k++)
            check_value("byte to chip", pay[k], model_bytes[k]);
         check_value("spi reply", {16'd0, pay[n-2] ^ 8'hA5, pay[n-1] ^ 8'hA5}, rep);
         check_value("chip selects released", 32'hFF, o_spi_cs);
         check_value("miso select", chip, o_spi_miso_sel);
      end
      exp_cs = 8'hFF;
      report_test();
   endtask

   task automatic backpressure_and_discard();
      logic [31:0] rep;
      start_test("backpressure and discard");
      send_frame(build_frame(OP_STATUS, 8'd6, 8'd1, 0, 0, 0, 0, 0));
      get_reply(1'b0, rep);
      check_value("fan old value", 32'd0, rep); // fan is off after reset
      i_tx_tready <= 1'b0;
      send_frame(build_frame(OP_STATUS, 8'd6, 8'd0, 0, 0, 0, 0, 0));
      get_reply(1'b1, rep);
      check_value("fan old value under stall", 32'd1, rep);
      check_value("fan output", 32'd0, o_fan_on);
      send_frame(build_frame(8'd7, 8'd0, 0, 0, 0, 0, 0, 0)); // not a kept opcode
      watch_for_no_beat(80);
      send_frame(build_frame(OP_STATUS, 8'd0, 0, 0, 0, 0, 0, 0));
      get_reply(1'b0, rep);
      check_value("version after discard", 32'd26, rep);
      report_test();
   endtask

   initial begin : main
      void'($urandom(18));
      pllreset2   = 1'b1;
      i_rx_tvalid = 1'b0;
      i_rx_tdata  = 8'h00;
      i_tx_tready = 1'b1;
      cur_test    = "reset";
      repeat (16) @(posedge clk50);
      pllreset2 <= 1'b0;
      @(posedge clk50);
      reset_state_check();
      trigger_settings();
      downsample_readback();
      status_fields();
      spi_transactions();
      backpressure_and_discard();
      close_run();
   end

endmodule

`default_nettype wire

// File: compile.f
logic/cmd_pkg.sv
logic/frame_receiver.sv
logic/cmd_sequencer.sv
logic/wait_timer.sv
logic/spi_transfer.sv
logic/settings_regs.sv
logic/usb_command_core.sv
verif/tb_usb_command_core.sv

// File: Bender.yml
package:
  name: usb_command_core

sources:
  - logic/cmd_pkg.sv
  - logic/frame_receiver.sv
  - logic/cmd_sequencer.sv
  - logic/wait_timer.sv
  - logic/spi_transfer.sv
  - logic/settings_regs.sv
  - logic/usb_command_core.sv
  - target: simulation
    files:
      - verif/tb_usb_command_core.sv
